// File: flist.f
+incdir+logic
logic/mmu_pkg.sv
logic/csr_pkg.sv
logic/dtlb.sv
logic/csr_regs.sv
logic/mem_resp_unit.sv
logic/mem_top.sv
test/tb_clkgen.sv
test/wb_mem_model.sv
test/mem_top_tb.sv

// File: logic/csr_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package csr_pkg;

   typedef enum logic [1:0] {
      e_csrrw = 2'b00,
      e_csrrs = 2'b01,
      e_csrrc = 2'b10
   } csr_op_e;

   // Machine CSRs implemented here
   typedef enum logic [`CSR_ADDR_WIDTH-1:0] {
      e_satp     = 12'h180,
      e_mtvec    = 12'h305,
      e_mscratch = 12'h340,
      e_mepc     = 12'h341
   } csr_addr_e;

endpackage

`default_nettype wire

// File: logic/csr_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_consts.svh"

module csr_regs (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        csr_cmd_v_i,
   input  csr_pkg::csr_op_e            csr_cmd_op_i,
   input  logic [`CSR_ADDR_WIDTH-1:0]  csr_cmd_addr_i,
   input  logic [`DATA_WIDTH-1:0]      csr_cmd_data_i,
   input  logic                        exception_v_i,
   input  logic [`VADDR_WIDTH-1:0]     exception_pc_i,
   output logic [`DATA_WIDTH-1:0]      csr_data_o,
   output logic                        csr_illegal_o,
   output logic                        csr_done_o,
   output logic                        translation_en_o,
   output logic [`DATA_WIDTH-1:0]      mepc_o,
   output logic [`DATA_WIDTH-1:0]      mtvec_o
);

   import csr_pkg::*;

   logic [`DATA_WIDTH-1:0] satp_q;
   logic [`DATA_WIDTH-1:0] mepc_q;
   logic [`DATA_WIDTH-1:0] mtvec_q;
   logic [`DATA_WIDTH-1:0] mscratch_q;

   logic [`DATA_WIDTH-1:0] old_val;
   logic [`DATA_WIDTH-1:0] new_val;
   logic                   illegal;
   logic                   wr_en;

   // Address decode and old value
   always_comb begin
      illegal = 1'b0;
      case (csr_cmd_addr_i)
         e_satp:     old_val = satp_q;
         e_mepc:     old_val = mepc_q;
         e_mtvec:    old_val = mtvec_q;
         e_mscratch: old_val = mscratch_q;
         default: begin
            old_val = '0;
            illegal = 1'b1;
         end
      endcase
   end

   always_comb begin
      case (csr_cmd_op_i)
         e_csrrw: new_val = csr_cmd_data_i;
         e_csrrs: new_val = old_val | csr_cmd_data_i;
         e_csrrc: new_val = old_val & ~csr_cmd_data_i;
         default: new_val = old_val;
      endcase
   end

   assign wr_en = csr_cmd_v_i && !illegal;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         satp_q        <= '0;
         mepc_q        <= '0;
         mtvec_q       <= '0;
         mscratch_q    <= '0;
         csr_data_o    <= '0;
         csr_illegal_o <= 1'b0;
         csr_done_o    <= 1'b0;
      end else begin
         csr_done_o    <= csr_cmd_v_i;
         csr_illegal_o <= csr_cmd_v_i && illegal;
         if (csr_cmd_v_i)
            csr_data_o <= old_val;
         if (wr_en && csr_cmd_addr_i == e_satp)
            satp_q <= new_val;
         if (wr_en && csr_cmd_addr_i == e_mtvec)
            mtvec_q <= new_val;
         if (wr_en && csr_cmd_addr_i == e_mscratch)
            mscratch_q <= new_val;
         // Exception capture overrides a software write
         if (exception_v_i)
            mepc_q <= {exception_pc_i[`VADDR_WIDTH-1:2], 2'b00};
         else if (wr_en && csr_cmd_addr_i == e_mepc)
            mepc_q <= new_val;
      end
   end

   // MODE bit of satp
   assign translation_en_o = satp_q[`DATA_WIDTH-1];
   assign mepc_o           = mepc_q;
   assign mtvec_o          = mtvec_q;

endmodule

`default_nettype wire

// File: logic/dtlb.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_consts.svh"

module dtlb (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    r_v_i,
   input  logic [`VTAG_WIDTH-1:0]  r_vtag_i,
   input  logic                    w_v_i,
   input  logic [`VTAG_WIDTH-1:0]  w_vtag_i,
   input  logic [`PTAG_WIDTH-1:0]  w_ptag_i,
   output logic [`PTAG_WIDTH-1:0]  r_ptag_o,
   output logic                    miss_o
);

   localparam int ENTRIES = `TLB_ENTRIES;
   localparam int IDX_W   = $clog2(ENTRIES);

   logic [ENTRIES-1:0]     valid_q;
   logic [`VTAG_WIDTH-1:0] vtag_q [ENTRIES];
   logic [`PTAG_WIDTH-1:0] ptag_q [ENTRIES];
   logic [IDX_W-1:0]       rr_q;

   logic [ENTRIES-1:0]     r_hit;
   logic [ENTRIES-1:0]     w_hit;
   logic [`PTAG_WIDTH-1:0] r_ptag_d;
   logic [IDX_W-1:0]       w_hit_idx;
   logic [IDX_W-1:0]       free_idx;
   logic                   free_found;
   logic [IDX_W-1:0]       w_idx;

   // Parallel tag compare, at most one hit so the ptags can be OR-ed
   always_comb begin
      r_ptag_d   = '0;
      w_hit_idx  = '0;
      free_idx   = '0;
      free_found = 1'b0;
      for (int i = 0; i < ENTRIES; i++) begin
         r_hit[i] = valid_q[i] && (vtag_q[i] == r_vtag_i);
         w_hit[i] = valid_q[i] && (vtag_q[i] == w_vtag_i);
         r_ptag_d = r_ptag_d | (ptag_q[i] & {`PTAG_WIDTH{r_hit[i]}});
         if (w_hit[i])
            w_hit_idx = IDX_W'(i);
         if (!valid_q[i] && !free_found) begin
            free_idx   = IDX_W'(i);
            free_found = 1'b1;
         end
      end
   end

   // Existing entry first, then a free slot, then the round-robin victim
   assign w_idx = (|w_hit) ? w_hit_idx : (free_found ? free_idx : rr_q);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_q <= '0;
         rr_q    <= '0;
         miss_o  <= 1'b0;
      end else begin
         miss_o <= r_v_i && !(|r_hit);
         if (w_v_i) begin
            valid_q[w_idx] <= 1'b1;
            if (!(|w_hit) && !free_found)
               rr_q <= rr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_v_i) begin
         vtag_q[w_idx] <= w_vtag_i;
         ptag_q[w_idx] <= w_ptag_i;
      end
      if (r_v_i)
         r_ptag_o <= r_ptag_d;
   end

   // Fills must never leave two entries with the same vtag
   a_single_match: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(r_hit) && $onehot0(w_hit));

endmodule

`default_nettype wire

// File: logic/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Address widths
`define VADDR_WIDTH 32
`define PADDR_WIDTH 32
`define PAGE_OFFSET_WIDTH 12

// Tags drop the page offset
`define VTAG_WIDTH (`VADDR_WIDTH - `PAGE_OFFSET_WIDTH)
`define PTAG_WIDTH (`PADDR_WIDTH - `PAGE_OFFSET_WIDTH)

`define DATA_WIDTH 32

// Fully associative, so entries are also ways
`define TLB_ENTRIES 8

`define CSR_ADDR_WIDTH 12

`endif

// File: logic/mem_resp_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_resp_unit (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         mmu_cmd_v_i,
   output logic                         mmu_cmd_ready_o,
   input  mmu_pkg::mmu_op_e             mmu_cmd_op_i,
   input  logic [`VADDR_WIDTH-1:0]      mmu_cmd_vaddr_i,
   input  logic [`DATA_WIDTH-1:0]       mmu_cmd_data_i,
   input  logic                         csr_cmd_v_i,
   output logic                         csr_cmd_ready_o,
   input  logic                         translation_en_i,
   input  logic [`PTAG_WIDTH-1:0]       tlb_r_ptag_i,
   input  logic                         tlb_miss_i,
   input  logic [`DATA_WIDTH-1:0]       csr_data_i,
   input  logic                         csr_illegal_i,
   input  logic                         csr_done_i,
   output logic                         tlb_r_v_o,
   output logic [`VTAG_WIDTH-1:0]       tlb_r_vtag_o,
   output logic                         tlb_w_v_o,
   output logic [`VTAG_WIDTH-1:0]       tlb_w_vtag_o,
   output logic [`PTAG_WIDTH-1:0]       tlb_w_ptag_o,
   output logic                         wb_cyc_o,
   output logic                         wb_stb_o,
   output logic                         wb_we_o,
   output logic [`PADDR_WIDTH-1:0]      wb_adr_o,
   output logic [`DATA_WIDTH-1:0]       wb_dat_o,
   output logic [`DATA_WIDTH/8-1:0]     wb_sel_o,
   input  logic [`DATA_WIDTH-1:0]       wb_dat_i,
   input  logic                         wb_ack_i,
   output logic [`DATA_WIDTH-1:0]       mem_resp_data_o,
   output logic                         mem_resp_tlb_miss_o,
   output logic                         mem_resp_illegal_o,
   output logic                         mem_resp_v_o,
   input  logic                         mem_resp_ready_i
);

   import mmu_pkg::*;

   resp_state_e             state_q;
   resp_state_e             state_n;
   logic                    cmd_csr_q;
   mmu_op_e                 op_q;
   logic [`VADDR_WIDTH-1:0] vaddr_q;
   logic [`DATA_WIDTH-1:0]  data_q;

   logic                    csr_accept;
   logic                    mmu_accept;
   logic                    xlate_miss;
   logic                    bus_go;
   logic [`PADDR_WIDTH-1:0] paddr;

   // CSR command has priority over a memory command
   assign csr_cmd_ready_o = (state_q == e_idle);
   assign mmu_cmd_ready_o = (state_q == e_idle) && !csr_cmd_v_i;
   assign csr_accept      = csr_cmd_v_i && csr_cmd_ready_o;
   assign mmu_accept      = mmu_cmd_v_i && mmu_cmd_ready_o;

   // Lookup and fill go out on the acceptance cycle
   assign tlb_r_v_o    = mmu_accept && translation_en_i && (mmu_cmd_op_i != e_tlb_fill);
   assign tlb_r_vtag_o = mmu_cmd_vaddr_i[`VADDR_WIDTH-1:`PAGE_OFFSET_WIDTH];
   assign tlb_w_v_o    = mmu_accept && (mmu_cmd_op_i == e_tlb_fill);
   assign tlb_w_vtag_o = mmu_cmd_vaddr_i[`VADDR_WIDTH-1:`PAGE_OFFSET_WIDTH];
   assign tlb_w_ptag_o = mmu_cmd_data_i[`PTAG_WIDTH-1:0];

   assign xlate_miss = translation_en_i && tlb_miss_i;
   assign bus_go     = (op_q != e_tlb_fill) && !xlate_miss;
   assign paddr      = translation_en_i ?
                       {tlb_r_ptag_i, vaddr_q[`PAGE_OFFSET_WIDTH-1:0]} : vaddr_q;

   // Word accesses only
   assign wb_sel_o     = '1;
   assign mem_resp_v_o = (state_q == e_resp);

   always_comb begin
      state_n = state_q;
      case (state_q)
         e_idle:
            if (csr_accept || mmu_accept)
               state_n = e_xlate;
         e_xlate: begin
            if (cmd_csr_q) begin
               if (csr_done_i)
                  state_n = e_resp;
            end else if (bus_go) begin
               state_n = e_bus;
            end else begin
               state_n = e_resp;
            end
         end
         e_bus:
            if (wb_ack_i)
               state_n = e_resp;
         e_resp:
            if (mem_resp_ready_i)
               state_n = e_idle;
         default: state_n = e_idle;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q   <= e_idle;
         cmd_csr_q <= 1'b0;
         wb_cyc_o  <= 1'b0;
         wb_stb_o  <= 1'b0;
      end else begin
         state_q <= state_n;
         if (csr_accept)
            cmd_csr_q <= 1'b1;
         else if (mmu_accept)
            cmd_csr_q <= 1'b0;
         if (state_q == e_xlate && !cmd_csr_q && bus_go) begin
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
         end else if (wb_cyc_o && wb_ack_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (mmu_accept) begin
         op_q    <= mmu_cmd_op_i;
         vaddr_q <= mmu_cmd_vaddr_i;
         data_q  <= mmu_cmd_data_i;
      end
      if (state_q == e_xlate) begin
         if (cmd_csr_q) begin
            mem_resp_data_o     <= csr_data_i;
            mem_resp_illegal_o  <= csr_illegal_i;
            mem_resp_tlb_miss_o <= 1'b0;
         end else begin
            // Fill and miss respond with zero data
            mem_resp_data_o     <= '0;
            mem_resp_illegal_o  <= 1'b0;
            mem_resp_tlb_miss_o <= (op_q != e_tlb_fill) && xlate_miss;
            wb_adr_o            <= paddr;
            wb_we_o             <= (op_q == e_store);
            wb_dat_o            <= data_q;
         end
      end
      if (state_q == e_bus && wb_ack_i)
         mem_resp_data_o <= wb_we_o ? '0 : wb_dat_i;
   end

   // Strobe only inside a cycle, and only while the FSM is on the bus
   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_stb_o |-> wb_cyc_o && (state_q == e_bus));

   // Bus request held steady until the slave acks
   a_bus_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable(wb_adr_o) && $stable(wb_dat_o));

   a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_resp_v_o && !mem_resp_ready_i |=> mem_resp_v_o && $stable(mem_resp_data_o)
         && $stable(mem_resp_tlb_miss_o) && $stable(mem_resp_illegal_o));

endmodule

`default_nettype wire

// File: logic/mem_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_consts.svh"

module mem_top (
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         mmu_cmd_v_i,
   output logic                         mmu_cmd_ready_o,
   input  mmu_pkg::mmu_op_e             mmu_cmd_op_i,
   input  logic [`VADDR_WIDTH-1:0]      mmu_cmd_vaddr_i,
   input  logic [`DATA_WIDTH-1:0]       mmu_cmd_data_i,
   input  logic                         csr_cmd_v_i,
   output logic                         csr_cmd_ready_o,
   input  csr_pkg::csr_op_e             csr_cmd_op_i,
   input  logic [`CSR_ADDR_WIDTH-1:0]   csr_cmd_addr_i,
   input  logic [`DATA_WIDTH-1:0]       csr_cmd_data_i,
   output logic [`DATA_WIDTH-1:0]       mem_resp_data_o,
   output logic                         mem_resp_tlb_miss_o,
   output logic                         mem_resp_illegal_o,
   output logic                         mem_resp_v_o,
   input  logic                         mem_resp_ready_i,
   output logic                         wb_cyc_o,
   output logic                         wb_stb_o,
   output logic                         wb_we_o,
   output logic [`PADDR_WIDTH-1:0]      wb_adr_o,
   output logic [`DATA_WIDTH-1:0]       wb_dat_o,
   output logic [`DATA_WIDTH/8-1:0]     wb_sel_o,
   input  logic [`DATA_WIDTH-1:0]       wb_dat_i,
   input  logic                         wb_ack_i,
   input  logic                         exception_v_i,
   input  logic [`VADDR_WIDTH-1:0]      exception_pc_i,
   output logic [`DATA_WIDTH-1:0]       mepc_o,
   output logic [`DATA_WIDTH-1:0]       mtvec_o
);

   logic                   tlb_r_v;
   logic [`VTAG_WIDTH-1:0] tlb_r_vtag;
   logic                   tlb_w_v;
   logic [`VTAG_WIDTH-1:0] tlb_w_vtag;
   logic [`PTAG_WIDTH-1:0] tlb_w_ptag;
   logic [`PTAG_WIDTH-1:0] tlb_r_ptag;
   logic                   tlb_miss;
   logic [`DATA_WIDTH-1:0] csr_data;
   logic                   csr_illegal;
   logic                   csr_done;
   logic                   translation_en;

   dtlb dtlb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .r_v_i    (tlb_r_v),
      .r_vtag_i (tlb_r_vtag),
      .w_v_i    (tlb_w_v),
      .w_vtag_i (tlb_w_vtag),
      .w_ptag_i (tlb_w_ptag),
      .r_ptag_o (tlb_r_ptag),
      .miss_o   (tlb_miss)
   );

   // CSR file only sees commands the response unit accepts
   csr_regs csr (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .csr_cmd_v_i      (csr_cmd_v_i & csr_cmd_ready_o),
      .csr_cmd_op_i     (csr_cmd_op_i),
      .csr_cmd_addr_i   (csr_cmd_addr_i),
      .csr_cmd_data_i   (csr_cmd_data_i),
      .exception_v_i    (exception_v_i),
      .exception_pc_i   (exception_pc_i),
      .csr_data_o       (csr_data),
      .csr_illegal_o    (csr_illegal),
      .csr_done_o       (csr_done),
      .translation_en_o (translation_en),
      .mepc_o           (mepc_o),
      .mtvec_o          (mtvec_o)
   );

   mem_resp_unit resp (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .mmu_cmd_v_i         (mmu_cmd_v_i),
      .mmu_cmd_ready_o     (mmu_cmd_ready_o),
      .mmu_cmd_op_i        (mmu_cmd_op_i),
      .mmu_cmd_vaddr_i     (mmu_cmd_vaddr_i),
      .mmu_cmd_data_i      (mmu_cmd_data_i),
      .csr_cmd_v_i         (csr_cmd_v_i),
      .csr_cmd_ready_o     (csr_cmd_ready_o),
      .translation_en_i    (translation_en),
      .tlb_r_ptag_i        (tlb_r_ptag),
      .tlb_miss_i          (tlb_miss),
      .csr_data_i          (csr_data),
      .csr_illegal_i       (csr_illegal),
      .csr_done_i          (csr_done),
      .tlb_r_v_o           (tlb_r_v),
      .tlb_r_vtag_o        (tlb_r_vtag),
      .tlb_w_v_o           (tlb_w_v),
      .tlb_w_vtag_o        (tlb_w_vtag),
      .tlb_w_ptag_o        (tlb_w_ptag),
      .wb_cyc_o            (wb_cyc_o),
      .wb_stb_o            (wb_stb_o),
      .wb_we_o             (wb_we_o),
      .wb_adr_o            (wb_adr_o),
      .wb_dat_o            (wb_dat_o),
      .wb_sel_o            (wb_sel_o),
      .wb_dat_i            (wb_dat_i),
      .wb_ack_i            (wb_ack_i),
      .mem_resp_data_o     (mem_resp_data_o),
      .mem_resp_tlb_miss_o (mem_resp_tlb_miss_o),
      .mem_resp_illegal_o  (mem_resp_illegal_o),
      .mem_resp_v_o        (mem_resp_v_o),
      .mem_resp_ready_i    (mem_resp_ready_i)
   );

endmodule

`default_nettype wire

// File: logic/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

   // Memory command opcodes
   typedef enum logic [1:0] {
      e_load     = 2'b00,
      e_store    = 2'b01,
      e_tlb_fill = 2'b10
   } mmu_op_e;

   // Response unit sequencing
   typedef enum logic [1:0] {
      e_idle  = 2'b00,
      e_xlate = 2'b01,
      e_bus   = 2'b10,
      e_resp  = 2'b11
   } resp_state_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_top \
   -f flist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

// File: test/mem_top_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "mem_consts.svh"

module tb_top;

   import mmu_pkg::*;
   import csr_pkg::*;

   localparam int TIMEOUT_CYCLES = 60;

   logic clk, reset_i;
   logic mmu_cmd_v_i, mmu_cmd_ready_o, csr_cmd_v_i, csr_cmd_ready_o;
   mmu_op_e mmu_cmd_op_i;
   csr_op_e csr_cmd_op_i;
   logic [31:0] mmu_cmd_vaddr_i, mmu_cmd_data_i, csr_cmd_data_i;
   logic [11:0] csr_cmd_addr_i;
   logic [31:0] mem_resp_data_o, wb_adr_o, wb_dat_o, wb_dat_i, exception_pc_i;
   logic [31:0] mepc_o, mtvec_o;
   logic mem_resp_tlb_miss_o, mem_resp_illegal_o, mem_resp_v_o, mem_resp_ready_i;
   logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i, exception_v_i;
   logic [3:0] wb_sel_o;

   // Reference model state
   logic [31:0] csr_model [4];
   logic [31:0] mem_model [int];
   logic [19:0] tlb_model [logic [19:0]];
   logic [31:0] exp_data, exp_adr, exp_wdat;
   logic exp_miss, exp_illegal, exp_we, bus_exp;
   string cur_test;

   tb_clkgen clkgen (.clk_o(clk));

   mem_top DUT (
      .clk_i(clk), .reset_i(reset_i),
      .mmu_cmd_v_i(mmu_cmd_v_i), .mmu_cmd_ready_o(mmu_cmd_ready_o),
      .mmu_cmd_op_i(mmu_cmd_op_i), .mmu_cmd_vaddr_i(mmu_cmd_vaddr_i),
      .mmu_cmd_data_i(mmu_cmd_data_i),
      .csr_cmd_v_i(csr_cmd_v_i), .csr_cmd_ready_o(csr_cmd_ready_o),
      .csr_cmd_op_i(csr_cmd_op_i), .csr_cmd_addr_i(csr_cmd_addr_i),
      .csr_cmd_data_i(csr_cmd_data_i),
      .mem_resp_data_o(mem_resp_data_o), .mem_resp_tlb_miss_o(mem_resp_tlb_miss_o),
      .mem_resp_illegal_o(mem_resp_illegal_o), .mem_resp_v_o(mem_resp_v_o),
      .mem_resp_ready_i(mem_resp_ready_i),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
      .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
      .exception_v_i(exception_v_i), .exception_pc_i(exception_pc_i),
      .mepc_o(mepc_o), .mtvec_o(mtvec_o)
   );

   wb_mem_model mem (
      .clk_i(clk), .reset_i(reset_i), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o),
      .we_i(wb_we_o), .adr_i(wb_adr_o), .dat_i(wb_dat_o), .sel_i(wb_sel_o),
      .dat_o(wb_dat_i), .ack_o(wb_ack_i)
   );

   task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic plain_error(input string what);
      $display("%s: %s", cur_test, what);
      $display("Result: FAILED");
      $fatal(1, "check failed");
   endtask

   // Checks against the model
   a_data: assert property (@(posedge clk) disable iff (reset_i)
      mem_resp_v_o && mem_resp_ready_i |-> mem_resp_data_o == exp_data)
      else value_error("response data", exp_data, $sampled(mem_resp_data_o));
   a_miss: assert property (@(posedge clk) disable iff (reset_i)
      mem_resp_v_o && mem_resp_ready_i |-> mem_resp_tlb_miss_o == exp_miss)
      else value_error("tlb miss", 32'(exp_miss), 32'($sampled(mem_resp_tlb_miss_o)));
   a_illegal: assert property (@(posedge clk) disable iff (reset_i)
      mem_resp_v_o && mem_resp_ready_i |-> mem_resp_illegal_o == exp_illegal)
      else value_error("illegal", 32'(exp_illegal), 32'($sampled(mem_resp_illegal_o)));
   a_adr: assert property (@(posedge clk) disable iff (reset_i)
      wb_cyc_o |-> wb_adr_o == exp_adr)
      else value_error("bus address", exp_adr, $sampled(wb_adr_o));
   a_we: assert property (@(posedge clk) disable iff (reset_i)
      wb_cyc_o |-> wb_we_o == exp_we)
      else value_error("bus write enable", 32'(exp_we), 32'($sampled(wb_we_o)));
   a_wdat: assert property (@(posedge clk) disable iff (reset_i)
      wb_cyc_o && exp_we |-> wb_dat_o == exp_wdat)
      else value_error("bus write data", exp_wdat, $sampled(wb_dat_o));
   a_sel: assert property (@(posedge clk) disable iff (reset_i)
      wb_cyc_o |-> wb_sel_o == 4'hf)
      else value_error("bus byte select", 32'h0000_000f, 32'($sampled(wb_sel_o)));
   a_stb: assert property (@(posedge clk) disable iff (reset_i)
      wb_stb_o == wb_cyc_o)
      else plain_error("wb_stb_o and wb_cyc_o did not move together");
   a_no_bus: assert property (@(posedge clk) disable iff (reset_i)
      !bus_exp |-> !wb_cyc_o)
      else plain_error("a bus cycle started during a command that needs none");
   a_stall: assert property (@(posedge clk) disable iff (reset_i)
      mem_resp_v_o && !mem_resp_ready_i |=> mem_resp_v_o && $stable(mem_resp_data_o)
         && $stable(mem_resp_tlb_miss_o) && $stable(mem_resp_illegal_o))
      else plain_error("the response changed while it was stalled");
   a_no_accept: assert property (@(posedge clk) disable iff (reset_i)
      mem_resp_v_o |-> !mmu_cmd_ready_o && !csr_cmd_ready_o)
      else plain_error("a ready output was high while a response was pending");
   a_mepc: assert property (@(posedge clk) disable iff (reset_i) mepc_o == csr_model[1])
      else value_error("mepc_o", csr_model[1], $sampled(mepc_o));
   a_mtvec: assert property (@(posedge clk) disable iff (reset_i) mtvec_o == csr_model[2])
      else value_error("mtvec_o", csr_model[2], $sampled(mtvec_o));

   function automatic int csr_index(input logic [11:0] a);
      case (a)
         12'h180: return 0;
         12'h341: return 1;
         12'h305: return 2;
         12'h340: return 3;
         default: return -1;
      endcase
   endfunction

   task automatic timed_out(input string what);
      $display("Timeout in %s: %s", cur_test, what);
      $display("Result: FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic wait_accept(input bit is_csr);
      int n;
      bit rdy;
      n = 0;
      rdy = 1'b0;
      while (!rdy) begin
         @(posedge clk);
         rdy = is_csr ? csr_cmd_ready_o : mmu_cmd_ready_o;
         n++;
         if (!rdy && n > TIMEOUT_CYCLES)
            timed_out("the command was never accepted");
      end
      mmu_cmd_v_i <= 1'b0;
      csr_cmd_v_i <= 1'b0;
   endtask

   task automatic wait_resp(input bit bp);
      int n;
      int span;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (!mem_resp_v_o && n > TIMEOUT_CYCLES)
            timed_out("no response arrived");
      end while (!mem_resp_v_o);
      if (bp) begin
         span = $urandom_range(6, 1);
         repeat (span) @(posedge clk);
         mem_resp_ready_i <= 1'b1;
         @(posedge clk);
      end
   endtask

   task automatic run_mem(input mmu_op_e op, input logic [31:0] va, input logic [31:0] d,
                          input bit bp);
      logic [31:0] pa;
      bit miss;
      pa = va;
      miss = 1'b0;
      exp_illegal = 1'b0;
      exp_data = '0;
      if (op == e_tlb_fill) begin
         bus_exp = 1'b0;
         exp_miss = 1'b0;
      end else begin
         if (csr_model[0][31]) begin
            if (tlb_model.exists(va[31:12]))
               pa = {tlb_model[va[31:12]], va[11:0]};
            else
               miss = 1'b1;
         end
         bus_exp = !miss;
         exp_miss = miss;
         exp_adr = pa;
         exp_we = (op == e_store);
         exp_wdat = d;
         if (!miss && op == e_store)
            mem_model[int'(pa[9:2])] = d;
         else if (!miss)
            exp_data = mem_model[int'(pa[9:2])];
      end
      mmu_cmd_op_i <= op;
      mmu_cmd_vaddr_i <= va;
      mmu_cmd_data_i <= d;
      mmu_cmd_v_i <= 1'b1;
      mem_resp_ready_i <= !bp;
      wait_accept(1'b0);
      if (op == e_tlb_fill)
         tlb_model[va[31:12]] = d[19:0];
      wait_resp(bp);
   endtask

   task automatic run_csr(input csr_op_e op, input logic [11:0] a, input logic [31:0] d,
                          input bit bp);
      int idx;
      logic [31:0] old_v;
      logic [31:0] new_v;
      idx = csr_index(a);
      old_v = (idx >= 0) ? csr_model[idx] : 32'h0;
      case (op)
         e_csrrs: new_v = old_v | d;
         e_csrrc: new_v = old_v & ~d;
         default: new_v = d;
      endcase
      bus_exp = 1'b0;
      exp_data = old_v;
      exp_illegal = (idx < 0);
      exp_miss = 1'b0;
      csr_cmd_op_i <= op;
      csr_cmd_addr_i <= a;
      csr_cmd_data_i <= d;
      csr_cmd_v_i <= 1'b1;
      mem_resp_ready_i <= !bp;
      wait_accept(1'b1);
      if (idx >= 0)
         csr_model[idx] = new_v;
      wait_resp(bp);
   endtask

   initial begin
      logic [11:0] addrs [4];
      logic [31:0] va;
      void'($urandom(32'ha9b1_38f6));
      addrs = '{12'h180, 12'h341, 12'h305, 12'h340};
      cur_test = "reset";
      for (int i = 0; i < 4; i++)
         csr_model[i] = '0;
      bus_exp = 1'b0;
      exp_adr = '0;
      exp_we = 1'b0;
      exp_wdat = '0;
      exp_data = '0;
      exp_miss = 1'b0;
      exp_illegal = 1'b0;
      reset_i = 1'b1;
      mmu_cmd_v_i = 1'b0;
      mmu_cmd_op_i = e_load;
      mmu_cmd_vaddr_i = '0;
      mmu_cmd_data_i = '0;
      csr_cmd_v_i = 1'b0;
      csr_cmd_op_i = e_csrrw;
      csr_cmd_addr_i = '0;
      csr_cmd_data_i = '0;
      mem_resp_ready_i = 1'b1;
      exception_v_i = 1'b0;
      exception_pc_i = '0;
      repeat (4) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      assert (!wb_cyc_o && !wb_stb_o && !mem_resp_v_o)
         else plain_error("bus or response valid high after reset");
      assert (mmu_cmd_ready_o && csr_cmd_ready_o)
         else plain_error("ready outputs low after reset");

      cur_test = "store_load_bare";
      run_mem(e_store, 32'h0000_0100, 32'hdead_beef, 1'b0);
      run_mem(e_load, 32'h0000_0100, 32'h0, 1'b0);
      run_mem(e_store, 32'h0000_02c4, 32'h1357_9bdf, 1'b0);
      run_mem(e_load, 32'h0000_02c4, 32'h0, 1'b0);

      cur_test = "csr_ops";
      for (int i = 0; i < 4; i++) begin
         run_csr(e_csrrw, addrs[i], $urandom() & 32'h7fff_ffff, 1'b0);
         run_csr(e_csrrs, addrs[i], $urandom() & 32'h7fff_ffff, 1'b0);
         run_csr(e_csrrc, addrs[i], $urandom(), 1'b0);
      end
      run_csr(e_csrrw, 12'h7c0, 32'hffff_ffff, 1'b0);
      for (int i = 0; i < 4; i++)
         run_csr(e_csrrs, addrs[i], 32'h0, 1'b0);

      cur_test = "exception";
      run_csr(e_csrrw, 12'h341, 32'h0000_4000, 1'b0);
      exception_pc_i <= 32'h8000_1237;
      exception_v_i <= 1'b1;
      @(posedge clk);
      csr_model[1] = 32'h8000_1234;
      exception_v_i <= 1'b0;
      repeat (2) @(posedge clk);
      run_csr(e_csrrw, 12'h305, 32'h0000_0800, 1'b0);

      cur_test = "tlb_translate";
      run_csr(e_csrrw, 12'h180, 32'h0, 1'b0);
      run_mem(e_tlb_fill, 32'h4000_0000, 32'h0000_0123, 1'b0);
      run_mem(e_tlb_fill, 32'h4000_1000, 32'h0000_0456, 1'b0);
      run_csr(e_csrrs, 12'h180, 32'h8000_0000, 1'b0);
      run_mem(e_store, 32'h4000_0010, 32'ha5a5_0001, 1'b0);
      run_mem(e_load, 32'h4000_0010, 32'h0, 1'b0);
      run_mem(e_store, 32'h4000_1020, 32'h5a5a_0002, 1'b0);
      run_mem(e_load, 32'h4000_1020, 32'h0, 1'b0);
      run_mem(e_load, 32'h7000_0040, 32'h0, 1'b0);
      run_mem(e_store, 32'h7000_0040, 32'h1111_2222, 1'b0);

      cur_test = "back_pressure";
      for (int i = 0; i < 6; i++) begin
         va = {20'h40001, 2'b00, 8'($urandom()), 2'b00};
         run_mem(e_store, va, $urandom(), 1'b1);
         run_mem(e_load, va, 32'h0, 1'b1);
         run_csr(e_csrrs, 12'h340, 32'h0, 1'b1);
      end
      run_mem(e_load, 32'h7000_0000, 32'h0, 1'b1);
      repeat (2) @(posedge clk);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: test/tb_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_o
);

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// File: test/wb_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module wb_mem_model (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o
);

   // 1 KiB of words
   logic [31:0] mem [256];
   logic [1:0]  wait_q;
   logic [7:0]  idx;
   logic [31:0] wmask;

   assign idx = adr_i[9:2];

   // Byte lanes enabled by the select lines
   assign wmask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0203);
   end

   always @(posedge clk_i) begin
      if (reset_i) begin
         ack_o  <= 1'b0;
         dat_o  <= '0;
         wait_q <= 2'($urandom_range(3, 0));
      end else if (ack_o) begin
         // Single-cycle ack, then a fresh wait count
         ack_o  <= 1'b0;
         wait_q <= 2'($urandom_range(3, 0));
      end else if (cyc_i && stb_i) begin
         if (wait_q == 2'd0) begin
            ack_o <= 1'b1;
            if (we_i)
               mem[idx] <= (mem[idx] & ~wmask) | (dat_i & wmask);
            else
               dat_o <= mem[idx];
         end else begin
            wait_q <= wait_q - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire
